/* compile.f */
hdl/dcache_pkg.sv
hdl/dcache_ram_if.sv
hdl/dcache_line_ram.sv
hdl/dcache_ctrl.sv
hdl/dcache_stats.sv
hdl/dcache_top.sv
dv/dcache_mem_model.sv
dv/dcache_properties.sv
dv/dcache_tb.sv

/* dv/dcache_tb.sv */
/*
  Data cache testbench: stimulus table, reference model of lines and memory,
  checks on read data, bus traffic and hit and miss counters
*/
`timescale 1ns/1ps

module dcache_tb import dcache_pkg::*; ();

	localparam int unsigned seed = 32'hf5f7;
	localparam int step_count = 36;
	localparam int mem_words = 256;
	localparam int init_cycles = line_count + 4;
	localparam int request_cycles = 24;
	localparam int flush_cycles = line_count * 12 + 4;

	localparam logic [1:0] op_read = 2'd0;
	localparam logic [1:0] op_write = 2'd1;
	localparam logic [1:0] op_flush = 2'd2;

	logic        clock;
	logic        reset;
	logic        request;
	logic        rw;
	logic        flush;
	logic        cacheable;
	logic [31:0] address;
	logic [31:0] wdata;
	logic        ready;
	logic [31:0] rdata;
	logic        bus_request;
	logic        bus_rw;
	logic [31:0] bus_address;
	logic [31:0] bus_wdata;
	logic        bus_ready;
	logic [31:0] bus_rdata;
	logic [31:0] hit_count;
	logic [31:0] miss_count;
	int          write_count;
	int          read_count;
	logic [31:0] last_write_address;
	logic [31:0] last_write_data;

	// Stimulus table with the bus writes each step must cause
	logic [1:0]  step_op        [step_count];
	logic        step_cacheable [step_count];
	logic [31:0] step_address   [step_count];
	logic [31:0] step_wdata     [step_count];
	int          step_writes    [step_count];
	int          table_pos;

	// Reference model of the lines and of the bus memory
	logic        model_valid [line_count];
	logic        model_dirty [line_count];
	logic [29:0] model_tag   [line_count];
	logic [31:0] model_data  [line_count];
	logic [31:0] shadow      [mem_words];
	int          exp_hits;
	int          exp_misses;
	int          exp_writes;
	int          exp_reads;
	logic [31:0] exp_rdata;
	logic [31:0] exp_write_address;
	logic [31:0] exp_write_data;

	int cycles = 0;
	int cycle_limit;

	dcache_top dut_i (
		.i_clock       (clock),
		.i_reset       (reset),
		.i_request     (request),
		.i_rw          (rw),
		.i_flush       (flush),
		.i_cacheable   (cacheable),
		.i_address     (address),
		.i_wdata       (wdata),
		.o_ready       (ready),
		.o_rdata       (rdata),
		.o_bus_request (bus_request),
		.o_bus_rw      (bus_rw),
		.o_bus_address (bus_address),
		.o_bus_wdata   (bus_wdata),
		.i_bus_ready   (bus_ready),
		.i_bus_rdata   (bus_rdata),
		.o_hit         (hit_count),
		.o_miss        (miss_count)
	);

	dcache_mem_model #(.seed(seed)) mem_i (
		.i_clock              (clock),
		.i_request            (bus_request),
		.i_rw                 (bus_rw),
		.i_address            (bus_address),
		.i_wdata              (bus_wdata),
		.o_ready              (bus_ready),
		.o_rdata              (bus_rdata),
		.o_write_count        (write_count),
		.o_read_count         (read_count),
		.o_last_write_address (last_write_address),
		.o_last_write_data    (last_write_data)
	);

	initial begin
		clock = 1'b0;
		forever begin
			#4 clock = ~clock;
		end
	end

	always @(posedge clock) begin
		cycles <= cycles + 1;
		if (dut_i.props_i.failure_count != 0) begin
			$display("a bound handshake assertion failed at %0t ns", $time);
			$display("CHECKS FAILED");
			$fatal(1);
		end else if (cycles >= cycle_limit) begin
			$display("timeout: the cache did not finish within %0d cycles", cycle_limit);
			$display("CHECKS FAILED");
			$fatal(1);
		end
	end

	task automatic report_mismatch(input int step, input string what,
		input logic [31:0] got, input logic [31:0] expected);
		$display("error at %0t ns: step %0d %s is %h, expected %h",
			$time, step, what, got, expected);
		$display("CHECKS FAILED");
		$fatal(1);
	endtask

	// Same preload rule as the bus memory
	function automatic logic [31:0] fill_word(input logic [31:0] word_address);
		return ({2'b00, word_address[31:2]} * 32'h9e37_79b1) ^ 32'h5bd1_e995;
	endfunction

	task automatic set_step(input logic [1:0] op, input logic cached,
		input logic [31:0] addr, input logic [31:0] data, input int writes);
		step_op[table_pos] = op;
		step_cacheable[table_pos] = cached;
		step_address[table_pos] = addr;
		step_wdata[table_pos] = data;
		step_writes[table_pos] = writes;
		table_pos++;
	endtask

	// ============================================================
	// Stimulus table
	// ============================================================
	task automatic load_table();
		table_pos = 0;
		set_step(op_read,  1'b1, 32'h010, 32'h0, 0);
		set_step(op_read,  1'b1, 32'h010, 32'h0, 0);
		set_step(op_write, 1'b1, 32'h024, 32'ha1a1_0001, 0);
		set_step(op_read,  1'b1, 32'h024, 32'h0, 0);
		set_step(op_write, 1'b1, 32'h024, 32'ha2a2_0002, 0);
		// Same index as the dirty line at 0x024
		set_step(op_read,  1'b1, 32'h064, 32'h0, 1);
		set_step(op_read,  1'b1, 32'h024, 32'h0, 0);
		set_step(op_write, 1'b1, 32'h030, 32'ha3a3_0003, 0);
		set_step(op_read,  1'b0, 32'h030, 32'h0, 0);
		set_step(op_write, 1'b0, 32'h034, 32'ha4a4_0004, 1);
		set_step(op_read,  1'b1, 32'h030, 32'h0, 0);
		set_step(op_read,  1'b1, 32'h034, 32'h0, 0);
		set_step(op_write, 1'b1, 32'h000, 32'ha5a5_0005, 0);
		set_step(op_write, 1'b1, 32'h03c, 32'ha6a6_0006, 0);
		set_step(op_write, 1'b1, 32'h010, 32'ha7a7_0007, 0);
		set_step(op_flush, 1'b1, 32'h000, 32'h0, 4);
		set_step(op_flush, 1'b1, 32'h000, 32'h0, 0);
		// Memory after the flush
		set_step(op_read,  1'b0, 32'h000, 32'h0, 0);
		set_step(op_read,  1'b0, 32'h010, 32'h0, 0);
		set_step(op_read,  1'b0, 32'h030, 32'h0, 0);
		set_step(op_read,  1'b0, 32'h03c, 32'h0, 0);
		set_step(op_read,  1'b0, 32'h024, 32'h0, 0);
		set_step(op_read,  1'b1, 32'h010, 32'h0, 0);
		set_step(op_write, 1'b1, 32'h050, 32'ha8a8_0008, 0);
		set_step(op_read,  1'b1, 32'h090, 32'h0, 1);
		set_step(op_write, 1'b0, 32'h090, 32'ha9a9_0009, 1);
		set_step(op_read,  1'b1, 32'h090, 32'h0, 0);
		set_step(op_write, 1'b1, 32'h03c, 32'haaaa_000a, 0);
		set_step(op_flush, 1'b1, 32'h000, 32'h0, 1);
		set_step(op_read,  1'b0, 32'h03c, 32'h0, 0);
		set_step(op_read,  1'b0, 32'h050, 32'h0, 0);
		set_step(op_write, 1'b1, 32'h0a4, 32'hbbbb_000b, 0);
		// Write miss over a dirty victim
		set_step(op_write, 1'b1, 32'h0e4, 32'hcccc_000c, 1);
		set_step(op_flush, 1'b1, 32'h000, 32'h0, 1);
		set_step(op_read,  1'b0, 32'h0e4, 32'h0, 0);
		set_step(op_read,  1'b0, 32'h0a4, 32'h0, 0);
	endtask

	// ============================================================
	// Reference model
	// ============================================================
	task automatic write_back(input int slot);
		exp_writes++;
		exp_write_address = {model_tag[slot], 2'b00};
		exp_write_data = model_data[slot];
		shadow[model_tag[slot][7:0]] = model_data[slot];
		model_dirty[slot] = 1'b0;
	endtask

	task automatic predict_step(input int i);
		int slot;
		logic [29:0] word;
		exp_writes = 0;
		exp_reads = 0;
		word = step_address[i][31:2];
		slot = step_address[i][index_bits+1:2];
		if (step_op[i] == op_flush) begin
			for (int l = 0; l < line_count; l++) begin
				if (model_dirty[l]) begin
					write_back(l);
				end
			end
		end else if (!step_cacheable[i]) begin
			if (step_op[i] == op_write) begin
				exp_writes = 1;
				exp_write_address = step_address[i];
				exp_write_data = step_wdata[i];
				shadow[word[7:0]] = step_wdata[i];
			end else begin
				exp_reads = 1;
				exp_rdata = shadow[word[7:0]];
			end
		end else begin
			if (model_valid[slot] && model_tag[slot] == word) begin
				exp_hits++;
			end else begin
				exp_misses++;
				if (model_dirty[slot]) begin
					write_back(slot);
				end
				model_valid[slot] = 1'b1;
				model_tag[slot] = word;
				if (step_op[i] == op_read) begin
					exp_reads = 1;
					model_data[slot] = shadow[word[7:0]];
				end
			end
			if (step_op[i] == op_write) begin
				model_data[slot] = step_wdata[i];
				model_dirty[slot] = 1'b1;
			end
			exp_rdata = model_data[slot];
		end
	endtask

	// Whole bus memory against the shadow copy
	task automatic compare_memory(input int step);
		for (int w = 0; w < mem_words; w++) begin
			assert (mem_i.words[w] === shadow[w])
			else report_mismatch(step, $sformatf("memory word %0d", w),
				mem_i.words[w], shadow[w]);
		end
	endtask

	// Starts and ends on a falling edge
	task automatic apply_step(input int i);
		int writes_before;
		int reads_before;
		logic [31:0] got_rdata;
		writes_before = write_count;
		reads_before = read_count;
		request = 1'b1;
		rw = (step_op[i] == op_write);
		flush = (step_op[i] == op_flush);
		cacheable = step_cacheable[i];
		address = step_address[i];
		wdata = step_wdata[i];
		do begin
			@(negedge clock);
		end while (ready !== 1'b1);
		got_rdata = rdata;
		request = 1'b0;
		// Counters settle one cycle after ready
		@(negedge clock);
		predict_step(i);
		if (step_op[i] == op_read) begin
			assert (got_rdata === exp_rdata)
			else report_mismatch(i, "read data", got_rdata, exp_rdata);
		end
		assert (write_count - writes_before == step_writes[i])
		else report_mismatch(i, "bus write count", write_count - writes_before, step_writes[i]);
		assert (write_count - writes_before == exp_writes)
		else report_mismatch(i, "model bus write count", write_count - writes_before, exp_writes);
		assert (read_count - reads_before == exp_reads)
		else report_mismatch(i, "bus read count", read_count - reads_before, exp_reads);
		if (exp_writes > 0) begin
			assert (last_write_address === exp_write_address)
			else report_mismatch(i, "bus write address", last_write_address, exp_write_address);
			assert (last_write_data === exp_write_data)
			else report_mismatch(i, "bus write data", last_write_data, exp_write_data);
		end
		assert (hit_count === exp_hits)
		else report_mismatch(i, "hit counter", hit_count, exp_hits);
		assert (miss_count === exp_misses)
		else report_mismatch(i, "miss counter", miss_count, exp_misses);
		if (step_op[i] == op_flush) begin
			compare_memory(i);
		end
	endtask

	initial begin
		reset = 1'b1;
		request = 1'b0;
		rw = 1'b0;
		flush = 1'b0;
		cacheable = 1'b0;
		address = '0;
		wdata = '0;
		exp_hits = 0;
		exp_misses = 0;
		load_table();
		for (int l = 0; l < line_count; l++) begin
			model_valid[l] = 1'b0;
			model_dirty[l] = 1'b0;
			model_tag[l] = '0;
			model_data[l] = '0;
		end
		for (int w = 0; w < mem_words; w++) begin
			shadow[w] = fill_word(w << 2);
		end
		cycle_limit = init_cycles;
		for (int i = 0; i < step_count; i++) begin
			cycle_limit += (step_op[i] == op_flush) ? flush_cycles : request_cycles;
		end

		repeat (2) @(negedge clock);
		reset = 1'b0;
		// Initialization sweep shows no handshake
		repeat (line_count + 2) begin
			@(negedge clock);
			assert (!ready && !bus_request)
			else begin
				$display("ready or a bus request came up during initialization");
				$display("CHECKS FAILED");
				$fatal(1);
			end
		end

		for (int i = 0; i < step_count; i++) begin
			apply_step(i);
		end

		if (dut_i.props_i.failure_count == 0) begin
			$display("ALL CHECKS PASSED");
			$finish;
		end else begin
			$display("CHECKS FAILED");
			$fatal(1);
		end
	end

endmodule

/* dv/dcache_properties.sv */
/*
  Bus and core handshake assertions, bound to the cache top level
*/
`timescale 1ns/1ps

module dcache_properties (
	input logic        i_clock,
	input logic        i_reset,
	input logic        i_ready,
	input logic        i_bus_request,
	input logic        i_bus_rw,
	input logic [31:0] i_bus_address,
	input logic [31:0] i_bus_wdata,
	input logic        i_bus_ready
);

	int failure_count = 0;

	// Request and its fields hold until the bus answers
	bus_request_held: assert property (@(posedge i_clock) disable iff (i_reset)
		i_bus_request && !i_bus_ready |=> i_bus_request && $stable(i_bus_rw) &&
			$stable(i_bus_address) && $stable(i_bus_wdata))
	else begin
		$error("bus request dropped or changed before ready");
		failure_count++;
	end

	ready_single_cycle: assert property (@(posedge i_clock) disable iff (i_reset)
		i_ready |=> !i_ready)
	else begin
		$error("core ready held longer than one cycle");
		failure_count++;
	end

	quiet_after_reset: assert property (@(posedge i_clock)
		i_reset |=> !i_ready && !i_bus_request)
	else begin
		$error("ready or bus request active after reset");
		failure_count++;
	end

endmodule

bind dcache_top dcache_properties props_i (
	.i_clock       (i_clock),
	.i_reset       (i_reset),
	.i_ready       (o_ready),
	.i_bus_request (o_bus_request),
	.i_bus_rw      (o_bus_rw),
	.i_bus_address (o_bus_address),
	.i_bus_wdata   (o_bus_wdata),
	.i_bus_ready   (i_bus_ready)
);

/* dv/dcache_mem_model.sv */
/*
  Behavioral bus memory with random ready delay and a write log
*/
`timescale 1ns/1ps

module dcache_mem_model #(
	parameter int unsigned seed = 1
) (
	input  logic        i_clock,
	input  logic        i_request,
	input  logic        i_rw,
	input  logic [31:0] i_address,
	input  logic [31:0] i_wdata,
	output logic        o_ready,
	output logic [31:0] o_rdata,
	output int          o_write_count,
	output int          o_read_count,
	output logic [31:0] o_last_write_address,
	output logic [31:0] o_last_write_data
);

	localparam int depth = 256;

	logic [31:0] words [depth];
	int unsigned delay;

	// Preload pattern over the whole word address
	function automatic logic [31:0] fill_pattern(input logic [31:0] address);
		return ({2'b00, address[31:2]} * 32'h9e37_79b1) ^ 32'h5bd1_e995;
	endfunction

	initial begin
		void'($urandom(seed));
		o_ready = 1'b0;
		o_rdata = '0;
		o_write_count = 0;
		o_read_count = 0;
		o_last_write_address = '0;
		o_last_write_data = '0;
		for (int i = 0; i < depth; i++) begin
			words[i] = fill_pattern(i << 2);
		end
		forever begin
			@(negedge i_clock);
			o_ready = 1'b0;
			if (i_request) begin
				// Ready after 1 to 4 cycles
				delay = 1 + ($urandom % 4);
				repeat (delay - 1) begin
					@(negedge i_clock);
				end
				if (i_rw) begin
					words[i_address[9:2]] = i_wdata;
					o_last_write_address = i_address;
					o_last_write_data = i_wdata;
					o_write_count = o_write_count + 1;
				end else begin
					o_rdata = words[i_address[9:2]];
					o_read_count = o_read_count + 1;
				end
				o_ready = 1'b1;
			end
		end
	end

endmodule

/* hdl/dcache_top.sv */
/*
  Data cache top level: controller, line store and debug counters
*/
`timescale 1ns/1ps

module dcache_top (
	input  logic        i_clock,
	input  logic        i_reset,

	// Core port
	input  logic        i_request,
	input  logic        i_rw,
	input  logic        i_flush,
	input  logic        i_cacheable,
	input  logic [31:0] i_address,
	input  logic [31:0] i_wdata,
	output logic        o_ready,
	output logic [31:0] o_rdata,

	// Bus port
	output logic        o_bus_request,
	output logic        o_bus_rw,
	output logic [31:0] o_bus_address,
	output logic [31:0] o_bus_wdata,
	input  logic        i_bus_ready,
	input  logic [31:0] i_bus_rdata,

	// Debug
	output logic [31:0] o_hit,
	output logic [31:0] o_miss
);

	logic hit_pulse;
	logic miss_pulse;

	dcache_ram_if ram_if ();

	dcache_ctrl ctrl_i (
		.i_clock       (i_clock),
		.i_reset       (i_reset),
		.i_request     (i_request),
		.i_rw          (i_rw),
		.i_flush       (i_flush),
		.i_cacheable   (i_cacheable),
		.i_address     (i_address),
		.i_wdata       (i_wdata),
		.o_ready       (o_ready),
		.o_rdata       (o_rdata),
		.o_bus_request (o_bus_request),
		.o_bus_rw      (o_bus_rw),
		.o_bus_address (o_bus_address),
		.o_bus_wdata   (o_bus_wdata),
		.i_bus_ready   (i_bus_ready),
		.i_bus_rdata   (i_bus_rdata),
		.ram           (ram_if.ctrl),
		.o_hit_pulse   (hit_pulse),
		.o_miss_pulse  (miss_pulse)
	);

	dcache_line_ram line_ram_i (
		.i_clock (i_clock),
		.ram     (ram_if.store)
	);

	dcache_stats stats_i (
		.i_clock      (i_clock),
		.i_reset      (i_reset),
		.i_hit_pulse  (hit_pulse),
		.i_miss_pulse (miss_pulse),
		.o_hit        (o_hit),
		.o_miss       (o_miss)
	);

endmodule

/* hdl/dcache_stats.sv */
/*
  Hit and miss event counters for debug
*/
`timescale 1ns/1ps

module dcache_stats (
	input  logic        i_clock,
	input  logic        i_reset,
	input  logic        i_hit_pulse,
	input  logic        i_miss_pulse,
	output logic [31:0] o_hit,
	output logic [31:0] o_miss
);

	// Both counters wrap around
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			o_hit <= '0;
			o_miss <= '0;
		end else begin
			if (i_hit_pulse) begin
				o_hit <= o_hit + 32'd1;
			end
			if (i_miss_pulse) begin
				o_miss <= o_miss + 32'd1;
			end
		end
	end

endmodule

/* hdl/dcache_ctrl.sv */
/*
  Data cache controller: hot line lookup, refill, write-back,
  uncached pass-through, flush sweep and initialization
*/
`timescale 1ns/1ps

module dcache_ctrl import dcache_pkg::*; (
	input  logic        i_clock,
	input  logic        i_reset,

	// Core side
	input  logic        i_request,
	input  logic        i_rw,
	input  logic        i_flush,
	input  logic        i_cacheable,
	input  logic [31:0] i_address,
	input  logic [31:0] i_wdata,
	output logic        o_ready,
	output logic [31:0] o_rdata,

	// Bus side
	output logic        o_bus_request,
	output logic        o_bus_rw,
	output logic [31:0] o_bus_address,
	output logic [31:0] o_bus_wdata,
	input  logic        i_bus_ready,
	input  logic [31:0] i_bus_rdata,

	dcache_ram_if.ctrl  ram,

	output logic        o_hit_pulse,
	output logic        o_miss_pulse
);

	logic [state_bits-1:0] state;
	logic [index_bits:0]   sweep;
	entry_t                line_entry;
	entry_t                new_entry;
	logic                  line_write;
	logic                  sweep_active;
	logic                  addr_match;
	logic                  victim_dirty;
	logic                  idle_accept;

	assign line_entry   = ram.rdata;
	assign addr_match   = line_entry.fields.valid &&
		(line_entry.fields.word_address == i_address[31:2]);
	// Dirty line that holds some other address
	assign victim_dirty = line_entry.fields.dirty && !addr_match;
	// Skip the cycle of our own ready pulse
	assign idle_accept  = i_request && !o_ready;

	assign sweep_active = (state == state_initialize) || (state == state_flush_setup) ||
		(state == state_flush_check) || (state == state_flush_write) ||
		(state == state_flush_next);

	assign ram.index = sweep_active ? sweep[index_bits-1:0] : i_address[index_bits+1:2];
	assign ram.write = line_write;
	assign ram.wdata = new_entry;

	// Line store writes take effect at the same edge as the state change
	always_comb begin
		line_write = 1'b0;
		new_entry.fields.data = i_wdata;
		new_entry.fields.word_address = i_address[31:2];
		new_entry.fields.dirty = 1'b1;
		new_entry.fields.valid = 1'b1;
		case (state)
			state_initialize: begin
				line_write = !sweep[index_bits];
				new_entry = entry_empty;
			end
			state_idle: begin
				line_write = idle_accept && !i_flush && i_cacheable && i_rw && addr_match;
			end
			state_write_setup: begin
				line_write = !victim_dirty;
			end
			state_write_wait: begin
				line_write = i_bus_ready;
			end
			state_read_bus_wait: begin
				line_write = o_bus_request && i_bus_ready;
				new_entry.fields.data = i_bus_rdata;
				new_entry.fields.dirty = 1'b0;
			end
			state_flush_write: begin
				// Same line written back clean
				line_write = i_bus_ready;
				new_entry = line_entry;
				new_entry.fields.dirty = 1'b0;
			end
			default: begin
				line_write = 1'b0;
			end
		endcase
	end

	always_ff @(posedge i_clock) begin
		o_ready <= 1'b0;
		o_hit_pulse <= 1'b0;
		o_miss_pulse <= 1'b0;

		case (state)
			state_idle: begin
				if (idle_accept) begin
					if (i_flush) begin
						sweep <= '0;
						state <= state_flush_setup;
					end else if (!i_cacheable) begin
						o_bus_rw <= i_rw;
						o_bus_address <= i_address;
						o_bus_wdata <= i_wdata;
						o_bus_request <= 1'b1;
						state <= state_pass_through;
					end else if (addr_match) begin
						// Hot line hit on a read or a write
						o_rdata <= line_entry.fields.data;
						o_ready <= 1'b1;
						o_hit_pulse <= 1'b1;
					end else if (i_rw) begin
						state <= state_write_setup;
					end else begin
						state <= state_read_setup;
					end
				end
			end

			// ============================================================
			// Flush sweep
			// ============================================================
			state_flush_setup: begin
				if (sweep[index_bits]) begin
					o_ready <= 1'b1;
					state <= state_idle;
				end else begin
					state <= state_flush_check;
				end
			end
			state_flush_check: begin
				if (line_entry.fields.dirty) begin
					o_bus_rw <= 1'b1;
					o_bus_address <= {line_entry.fields.word_address, 2'b00};
					o_bus_wdata <= line_entry.fields.data;
					o_bus_request <= 1'b1;
					state <= state_flush_write;
				end else begin
					sweep <= sweep + 1'b1;
					state <= state_flush_setup;
				end
			end
			state_flush_write: begin
				if (i_bus_ready) begin
					o_bus_request <= 1'b0;
					state <= state_flush_next;
				end
			end
			state_flush_next: begin
				sweep <= sweep + 1'b1;
				state <= state_flush_setup;
			end

			state_pass_through: begin
				if (i_bus_ready) begin
					o_bus_request <= 1'b0;
					o_rdata <= i_bus_rdata;
					o_ready <= 1'b1;
					state <= state_idle;
				end
			end

			// ============================================================
			// Cached write
			// ============================================================
			state_write_setup: begin
				o_hit_pulse <= addr_match;
				o_miss_pulse <= !addr_match;
				if (victim_dirty) begin
					o_bus_rw <= 1'b1;
					o_bus_address <= {line_entry.fields.word_address, 2'b00};
					o_bus_wdata <= line_entry.fields.data;
					o_bus_request <= 1'b1;
					state <= state_write_wait;
				end else begin
					o_ready <= 1'b1;
					state <= state_idle;
				end
			end
			state_write_wait: begin
				if (i_bus_ready) begin
					o_bus_request <= 1'b0;
					o_ready <= 1'b1;
					state <= state_idle;
				end
			end

			// ============================================================
			// Cached read
			// ============================================================
			state_read_setup: begin
				if (addr_match) begin
					o_rdata <= line_entry.fields.data;
					o_ready <= 1'b1;
					o_hit_pulse <= 1'b1;
					state <= state_idle;
				end else begin
					o_miss_pulse <= 1'b1;
					o_bus_request <= 1'b1;
					if (victim_dirty) begin
						o_bus_rw <= 1'b1;
						o_bus_address <= {line_entry.fields.word_address, 2'b00};
						o_bus_wdata <= line_entry.fields.data;
						state <= state_read_wb_wait;
					end else begin
						o_bus_rw <= 1'b0;
						o_bus_address <= i_address;
						state <= state_read_bus_wait;
					end
				end
			end
			state_read_wb_wait: begin
				if (i_bus_ready) begin
					o_bus_request <= 1'b0;
					state <= state_read_bus_wait;
				end
			end
			state_read_bus_wait: begin
				// After a write-back the fetch starts one cycle later
				if (!o_bus_request) begin
					o_bus_rw <= 1'b0;
					o_bus_address <= i_address;
					o_bus_request <= 1'b1;
				end else if (i_bus_ready) begin
					o_bus_request <= 1'b0;
					o_rdata <= i_bus_rdata;
					o_ready <= 1'b1;
					state <= state_idle;
				end
			end

			state_initialize: begin
				if (!sweep[index_bits]) begin
					sweep <= sweep + 1'b1;
				end else begin
					sweep <= '0;
					state <= state_idle;
				end
			end

			default: begin
				state <= state_idle;
			end
		endcase

		if (i_reset) begin
			state <= state_initialize;
			sweep <= '0;
			o_ready <= 1'b0;
			o_bus_request <= 1'b0;
			o_hit_pulse <= 1'b0;
			o_miss_pulse <= 1'b0;
		end
	end

endmodule

/* hdl/dcache_line_ram.sv */
/*
  Single-port line store with registered read and synchronous write
*/
`timescale 1ns/1ps

module dcache_line_ram import dcache_pkg::*; (
	input logic         i_clock,
	dcache_ram_if.store ram
);

	logic [63:0] lines [line_count];

	// A write at this edge reaches rdata one cycle later
	always_ff @(posedge i_clock) begin
		if (ram.write) begin
			lines[ram.index] <= ram.wdata.raw;
		end
		ram.rdata.raw <= lines[ram.index];
	end

endmodule

/* hdl/dcache_ram_if.sv */
/*
  Port between the cache controller and the line store
*/
`timescale 1ns/1ps

interface dcache_ram_if import dcache_pkg::*; ();

	logic                  write;
	logic [index_bits-1:0] index;
	entry_t                wdata;
	// Entry at the index of the previous cycle
	entry_t                rdata;

	modport ctrl (
		output write,
		output index,
		output wdata,
		input  rdata
	);

	modport store (
		input  write,
		input  index,
		input  wdata,
		output rdata
	);

endinterface

/* hdl/dcache_pkg.sv */
/*
  Data cache package: geometry, controller state encodings,
  line entry union and the empty entry constant
*/
package dcache_pkg;

	// Geometry
	localparam int index_bits = 4;
	localparam int line_count = 1 << index_bits;

	// Controller states
	localparam int state_bits = 4;
	localparam logic [state_bits-1:0] state_idle          = 4'd0;
	localparam logic [state_bits-1:0] state_flush_setup   = 4'd1;
	localparam logic [state_bits-1:0] state_flush_check   = 4'd2;
	localparam logic [state_bits-1:0] state_flush_write   = 4'd3;
	localparam logic [state_bits-1:0] state_flush_next    = 4'd4;
	localparam logic [state_bits-1:0] state_pass_through  = 4'd5;
	localparam logic [state_bits-1:0] state_write_setup   = 4'd6;
	localparam logic [state_bits-1:0] state_write_wait    = 4'd7;
	localparam logic [state_bits-1:0] state_read_setup    = 4'd8;
	localparam logic [state_bits-1:0] state_read_wb_wait  = 4'd9;
	localparam logic [state_bits-1:0] state_read_bus_wait = 4'd10;
	localparam logic [state_bits-1:0] state_initialize    = 4'd11;

	// One cache line, seen as a raw word by the store and as fields by the controller
	typedef union packed {
		logic [63:0] raw;
		struct packed {
			logic [31:0] data;
			logic [29:0] word_address;
			logic        dirty;
			logic        valid;
		} fields;
	} entry_t;

	// Invalid and clean
	localparam entry_t entry_empty = '0;

endpackage
